// ==== verilog/qspi_pkg.sv ====
package qspi_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  nibble_t;
    typedef logic [3:0]  nib_cnt_t;
    typedef logic [3:0]  dummy_cnt_t;

    // transfer phases, one serial clock per nibble or dummy cycle
    typedef enum logic [2:0] {
        IDLE,
        CMD,
        ADDR,
        DUMMY,
        RDATA,
        WDATA
    } phase_t;

    // register byte offsets
    localparam reg_addr_t CYCLE_REG = 5'd0;
    localparam reg_addr_t WDATA_REG = 5'd4;
    localparam reg_addr_t RDATA_REG = 5'd8;
    localparam reg_addr_t ADDR_REG  = 5'd12;
    localparam reg_addr_t CMD_REG   = 5'd16;
    localparam reg_addr_t CTRL_REG  = 5'd20;

    // cycle register fields
    localparam int ADDR_NIB_LSB = 0;
    localparam int DUMMY_LSB    = 4;
    localparam int DATA_NIB_LSB = 8;

    // control write bits
    localparam int CTRL_START_RD = 0;
    localparam int CTRL_START_WR = 1;
    localparam int CTRL_LSB      = 2;

    // control read bits
    localparam int STAT_BUSY    = 0;
    localparam int STAT_RD_DONE = 1;
    localparam int STAT_WR_DONE = 2;
    localparam int STAT_LSB     = 3;

    localparam nib_cnt_t CMD_NIBBLES  = 4'd2;
    localparam nib_cnt_t MAX_ADDR_NIB = 4'd6;

endpackage

// ==== verilog/qspi_regs.sv ====
`timescale 1ns/1ps

module qspi_regs (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 we_i,
    input  logic                 re_i,
    input  qspi_pkg::reg_addr_t  addr_i,
    input  qspi_pkg::word_t      wdata_i,
    input  logic                 busy_i,
    input  logic                 done_read_i,
    input  logic                 done_write_i,
    input  qspi_pkg::word_t      rx_word_i,
    output qspi_pkg::word_t      rdata_o,
    output logic                 start_read_o,
    output logic                 start_write_o,
    output logic                 lsb_first_o,
    output qspi_pkg::nib_cnt_t   addr_nib_o,
    output qspi_pkg::dummy_cnt_t dummy_o,
    output qspi_pkg::nib_cnt_t   data_nib_o,
    output qspi_pkg::word_t      cmd_o,
    output qspi_pkg::word_t      addr_o,
    output qspi_pkg::word_t      wdata_o,
    output logic                 intr_rx_o,
    output logic                 intr_tx_o
);
    import qspi_pkg::*;

    word_t    cycle_q;
    word_t    wdata_q;
    word_t    rdata_q;
    word_t    addr_q;
    word_t    cmd_q;
    logic     lsb_q;
    logic     rd_done_q;
    logic     wr_done_q;
    logic     ctrl_wr;
    nib_cnt_t addr_nib_raw;
    word_t    status;
    word_t    rd_mux;

    // control writes only count while the sequencer is idle
    assign ctrl_wr       = we_i && (addr_i == CTRL_REG) && !busy_i;
    assign start_read_o  = ctrl_wr && wdata_i[CTRL_START_RD];
    assign start_write_o = ctrl_wr && wdata_i[CTRL_START_WR] && !wdata_i[CTRL_START_RD];

    // new order bit reaches the transmitter in the same cycle as the start
    assign lsb_first_o = ctrl_wr ? wdata_i[CTRL_LSB] : lsb_q;

    assign addr_nib_raw = cycle_q[ADDR_NIB_LSB +: $bits(nib_cnt_t)];
    assign addr_nib_o   = (addr_nib_raw > MAX_ADDR_NIB) ? MAX_ADDR_NIB : addr_nib_raw;
    assign dummy_o      = cycle_q[DUMMY_LSB +: $bits(dummy_cnt_t)];
    assign data_nib_o   = cycle_q[DATA_NIB_LSB +: $bits(nib_cnt_t)];

    assign cmd_o     = cmd_q;
    assign addr_o    = addr_q;
    assign wdata_o   = wdata_q;
    assign intr_rx_o = rd_done_q;
    assign intr_tx_o = wr_done_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cycle_q   <= '0;
            lsb_q     <= 1'b0;
            rd_done_q <= 1'b0;
            wr_done_q <= 1'b0;
            rdata_o   <= '0;
        end else begin
            if (we_i && (addr_i == CYCLE_REG)) begin
                cycle_q <= wdata_i;
            end
            if (ctrl_wr) begin
                lsb_q <= wdata_i[CTRL_LSB];
            end
            if (start_read_o || start_write_o) begin
                rd_done_q <= 1'b0;
                wr_done_q <= 1'b0;
            end else begin
                if (done_read_i) begin
                    rd_done_q <= 1'b1;
                end
                if (done_write_i) begin
                    wr_done_q <= 1'b1;
                end
            end
            if (re_i) begin
                rdata_o <= rd_mux;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (we_i && (addr_i == WDATA_REG)) begin
            wdata_q <= wdata_i;
        end
        if (we_i && (addr_i == ADDR_REG)) begin
            addr_q <= wdata_i;
        end
        if (we_i && (addr_i == CMD_REG)) begin
            cmd_q <= word_t'(wdata_i[7:0]);
        end
        if (done_read_i) begin
            rdata_q <= rx_word_i;
        end
    end

    always_comb begin
        status               = '0;
        status[STAT_BUSY]    = busy_i;
        status[STAT_RD_DONE] = rd_done_q;
        status[STAT_WR_DONE] = wr_done_q;
        status[STAT_LSB]     = lsb_q;
    end

    always_comb begin
        case (addr_i)
            CYCLE_REG: rd_mux = cycle_q;
            WDATA_REG: rd_mux = wdata_q;
            RDATA_REG: rd_mux = rdata_q;
            ADDR_REG:  rd_mux = addr_q;
            CMD_REG:   rd_mux = cmd_q;
            CTRL_REG:  rd_mux = status;
            default:   rd_mux = '0;
        endcase
    end

endmodule

// ==== verilog/qspi_sequencer.sv ====
`timescale 1ns/1ps

module qspi_sequencer (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 start_read_i,
    input  logic                 start_write_i,
    input  qspi_pkg::nib_cnt_t   addr_nib_i,
    input  qspi_pkg::dummy_cnt_t dummy_i,
    input  qspi_pkg::nib_cnt_t   data_nib_i,
    output logic                 sclk_o,
    output logic                 csb_o,
    output qspi_pkg::nibble_t    qspi_oe_o,
    output logic                 tx_load_o,
    output qspi_pkg::phase_t     tx_sel_o,
    output logic                 tx_shift_o,
    output logic                 rx_clear_o,
    output logic                 rx_sample_o,
    output logic                 busy_o,
    output logic                 done_read_o,
    output logic                 done_write_o
);
    import qspi_pkg::*;

    phase_t   phase_q;
    phase_t   phase_d;
    phase_t   data_phase;
    logic     rd_q;
    nib_cnt_t cnt_q;
    nib_cnt_t len;
    logic     last;
    logic     drive_d;

    // serial clocks in the current phase
    always_comb begin
        case (phase_q)
            CMD:     len = CMD_NIBBLES;
            ADDR:    len = addr_nib_i;
            DUMMY:   len = nib_cnt_t'(dummy_i);
            RDATA:   len = data_nib_i;
            WDATA:   len = data_nib_i;
            default: len = '0;
        endcase
    end

    // phase ends on the high half of its final serial clock
    assign last = sclk_o && (cnt_q == len - 1'b1);

    // what follows the address, or the command when there is no address
    assign data_phase = !rd_q ? WDATA : ((dummy_i != '0) ? DUMMY : RDATA);

    always_comb begin
        phase_d = phase_q;
        unique case (phase_q)
            IDLE: begin
                if (start_read_i || start_write_i) begin
                    phase_d = CMD;
                end
            end
            CMD: begin
                if (last) begin
                    phase_d = (addr_nib_i != '0) ? ADDR : data_phase;
                end
            end
            ADDR: begin
                if (last) begin
                    phase_d = data_phase;
                end
            end
            DUMMY: begin
                if (last) begin
                    phase_d = RDATA;
                end
            end
            default: begin
                if (last) begin
                    phase_d = IDLE;
                end
            end
        endcase
    end

    assign drive_d = phase_d inside {CMD, ADDR, WDATA};

    // transmitter loads on the edge that opens a driven phase
    assign tx_load_o   = (phase_d != phase_q) && drive_d;
    assign tx_sel_o    = phase_d;
    assign tx_shift_o  = sclk_o;
    assign rx_clear_o  = start_read_i;
    assign rx_sample_o = (phase_q == RDATA) && !sclk_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            phase_q      <= IDLE;
            rd_q         <= 1'b0;
            cnt_q        <= '0;
            sclk_o       <= 1'b0;
            csb_o        <= 1'b1;
            qspi_oe_o    <= '0;
            busy_o       <= 1'b0;
            done_read_o  <= 1'b0;
            done_write_o <= 1'b0;
        end else begin
            phase_q <= phase_d;
            if (phase_q == IDLE && (start_read_i || start_write_i)) begin
                rd_q <= start_read_i;
            end
            if (phase_d != phase_q) begin
                cnt_q <= '0;
            end else if (sclk_o) begin
                cnt_q <= cnt_q + 1'b1;
            end
            sclk_o       <= (phase_q != IDLE) ? !sclk_o : 1'b0;
            csb_o        <= (phase_d == IDLE);
            qspi_oe_o    <= {4{drive_d}};
            // busy covers the cycle after chip select rises
            busy_o       <= (phase_d != IDLE) || (phase_q != IDLE);
            done_read_o  <= last && (phase_q == RDATA);
            done_write_o <= last && (phase_q == WDATA);
        end
    end

endmodule

// ==== verilog/qspi_tx_shift.sv ====
`timescale 1ns/1ps

module qspi_tx_shift (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               load_i,
    input  qspi_pkg::phase_t   sel_i,
    input  logic               shift_i,
    input  logic               lsb_first_i,
    input  qspi_pkg::nib_cnt_t nibbles_i,
    input  qspi_pkg::word_t    cmd_i,
    input  qspi_pkg::word_t    addr_i,
    input  qspi_pkg::word_t    wdata_i,
    output qspi_pkg::nibble_t  qspi_o
);
    import qspi_pkg::*;

    word_t      src;
    logic [5:0] shamt;
    word_t      sh_q;
    logic       lsb_q;

    always_comb begin
        case (sel_i)
            CMD:     src = cmd_i;
            ADDR:    src = addr_i;
            WDATA:   src = wdata_i;
            default: src = '0;
        endcase
    end

    // msb first puts nibble N-1 at the top of the word
    assign shamt = {4'd8 - nibbles_i, 2'b00};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sh_q  <= '0;
            lsb_q <= 1'b0;
        end else if (load_i) begin
            lsb_q <= lsb_first_i;
            sh_q  <= lsb_first_i ? src : (src << shamt);
        end else if (shift_i) begin
            sh_q <= lsb_q ? (sh_q >> 4) : (sh_q << 4);
        end
    end

    assign qspi_o = lsb_q ? sh_q[3:0] : sh_q[31:28];

endmodule

// ==== verilog/qspi_rx_shift.sv ====
`timescale 1ns/1ps

module qspi_rx_shift (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               clear_i,
    input  logic               sample_i,
    input  logic               lsb_first_i,
    input  qspi_pkg::nib_cnt_t nibbles_i,
    input  qspi_pkg::nibble_t  qspi_i,
    output qspi_pkg::word_t    word_o
);
    import qspi_pkg::*;

    word_t    word_q;
    nib_cnt_t idx_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            word_q <= '0;
            idx_q  <= '0;
        end else if (clear_i) begin
            word_q <= '0;
            idx_q  <= '0;
        end else if (sample_i && (idx_q < nibbles_i)) begin
            if (lsb_first_i) begin
                // first nibble lands in bits 3..0
                word_q[{idx_q[2:0], 2'b00} +: 4] <= qspi_i;
            end else begin
                word_q <= {word_q[27:0], qspi_i};
            end
            idx_q <= idx_q + 1'b1;
        end
    end

    assign word_o = word_q;

endmodule

// ==== verilog/qspi_core.sv ====
`timescale 1ns/1ps

module qspi_core (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                we_i,
    input  logic                re_i,
    input  qspi_pkg::reg_addr_t addr_i,
    input  qspi_pkg::word_t     wdata_i,
    output qspi_pkg::word_t     rdata_o,
    output logic                sclk_o,
    output logic                csb_o,
    output qspi_pkg::nibble_t   qspi_o,
    output qspi_pkg::nibble_t   qspi_oe_o,
    input  qspi_pkg::nibble_t   qspi_i,
    output logic                intr_rx_o,
    output logic                intr_tx_o
);
    import qspi_pkg::*;

    logic       start_read;
    logic       start_write;
    logic       lsb_first;
    nib_cnt_t   addr_nib;
    dummy_cnt_t dummy;
    nib_cnt_t   data_nib;
    word_t      cmd_word;
    word_t      addr_word;
    word_t      wdata_word;
    word_t      rx_word;
    logic       busy;
    logic       done_read;
    logic       done_write;
    logic       tx_load;
    phase_t     tx_sel;
    logic       tx_shift;
    logic       rx_clear;
    logic       rx_sample;
    nib_cnt_t   tx_nibbles;

    // nibble count of the field being loaded
    always_comb begin
        case (tx_sel)
            CMD:     tx_nibbles = CMD_NIBBLES;
            ADDR:    tx_nibbles = addr_nib;
            default: tx_nibbles = data_nib;
        endcase
    end

    qspi_regs u_regs (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .we_i          (we_i),
        .re_i          (re_i),
        .addr_i        (addr_i),
        .wdata_i       (wdata_i),
        .busy_i        (busy),
        .done_read_i   (done_read),
        .done_write_i  (done_write),
        .rx_word_i     (rx_word),
        .rdata_o       (rdata_o),
        .start_read_o  (start_read),
        .start_write_o (start_write),
        .lsb_first_o   (lsb_first),
        .addr_nib_o    (addr_nib),
        .dummy_o       (dummy),
        .data_nib_o    (data_nib),
        .cmd_o         (cmd_word),
        .addr_o        (addr_word),
        .wdata_o       (wdata_word),
        .intr_rx_o     (intr_rx_o),
        .intr_tx_o     (intr_tx_o)
    );

    qspi_sequencer u_sequencer (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .start_read_i  (start_read),
        .start_write_i (start_write),
        .addr_nib_i    (addr_nib),
        .dummy_i       (dummy),
        .data_nib_i    (data_nib),
        .sclk_o        (sclk_o),
        .csb_o         (csb_o),
        .qspi_oe_o     (qspi_oe_o),
        .tx_load_o     (tx_load),
        .tx_sel_o      (tx_sel),
        .tx_shift_o    (tx_shift),
        .rx_clear_o    (rx_clear),
        .rx_sample_o   (rx_sample),
        .busy_o        (busy),
        .done_read_o   (done_read),
        .done_write_o  (done_write)
    );

    qspi_tx_shift u_tx_shift (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .load_i      (tx_load),
        .sel_i       (tx_sel),
        .shift_i     (tx_shift),
        .lsb_first_i (lsb_first),
        .nibbles_i   (tx_nibbles),
        .cmd_i       (cmd_word),
        .addr_i      (addr_word),
        .wdata_i     (wdata_word),
        .qspi_o      (qspi_o)
    );

    qspi_rx_shift u_rx_shift (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .clear_i     (rx_clear),
        .sample_i    (rx_sample),
        .lsb_first_i (lsb_first),
        .nibbles_i   (data_nib),
        .qspi_i      (qspi_i),
        .word_o      (rx_word)
    );

endmodule

// ==== test/qspi_core_props.sv ====
`timescale 1ns/1ps

module qspi_core_props (
    input logic              clk_i,
    input logic              rst_ni,
    input logic              sclk_i,
    input logic              csb_i,
    input logic              start_i,
    input qspi_pkg::nibble_t data_i,
    input qspi_pkg::nibble_t oe_i
);

    // deselected flash sees a quiet bus
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        csb_i |-> (!sclk_i && oe_i == '0))
        else $error("sclk or lane enable active while chip select is high");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        sclk_i |-> $stable(data_i))
        else $error("qspi_o changed while sclk_o is high");

    // chip select only falls after a start
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (csb_i && !start_i) |=> csb_i)
        else $error("chip select fell without a start");

endmodule

bind qspi_core qspi_core_props u_props (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .sclk_i  (sclk_o),
    .csb_i   (csb_o),
    .start_i (start_read || start_write),
    .data_i  (qspi_o),
    .oe_i    (qspi_oe_o)
);

// ==== test/qspi_core_tb.sv ====
`timescale 1ns/1ps

module qspi_core_tb;
    import qspi_pkg::*;

    localparam int NUM_XFERS    = 60;
    localparam int RESET_CYCLES = 10;
    localparam int FLASH_DEPTH  = 32;
    // longest chip select window plus the bus traffic around it
    localparam int XFER_CYCLES  = 2 * (2 + 6 + 15 + 8) + 40;
    localparam int MAX_CYCLES   = RESET_CYCLES + NUM_XFERS * XFER_CYCLES;

    logic      clk_i;
    logic      rst_ni;
    logic      we_i;
    logic      re_i;
    reg_addr_t addr_i;
    word_t     wdata_i;
    word_t     rdata_o;
    logic      sclk_o;
    logic      csb_o;
    nibble_t   qspi_o;
    nibble_t   qspi_oe_o;
    nibble_t   qspi_i = '0;
    logic      intr_rx_o;
    logic      intr_tx_o;

    logic [31:0] lfsr_q = 32'h566;
    int          cycle_cnt = 0;

    // transfer under test, written before each start
    logic    cur_read;
    logic    cur_lsb;
    int      cur_a;
    int      cur_d;
    int      cur_n;
    nibble_t flash_mem [0:FLASH_DEPTH-1];
    nibble_t exp_q [$];

    // flash model state
    int      csb_cycles = 0;
    int      csb_falls  = 0;
    int      sck_idx    = 0;
    logic    csb_prev   = 1'b1;
    nibble_t tx_q [$];
    nibble_t rx_q [$];

    qspi_core dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic word_t take_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // wire position of the j-th nibble of an n-nibble field
    function automatic int nib_pos(input int j, input int n, input logic lsb);
        if (lsb) begin
            return j;
        end else begin
            return n - 1 - j;
        end
    endfunction

    function automatic nibble_t expected_oe(input int k);
        if (!cur_read || k < 2 + cur_a) begin
            return 4'hF;
        end else begin
            return 4'h0;
        end
    endfunction

    function automatic word_t read_model();
        word_t w;
        w = '0;
        for (int j = 0; j < rx_q.size(); j++) begin
            w[4 * nib_pos(j, cur_n, cur_lsb) +: 4] = rx_q[j];
        end
        return w;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_nibble(input string name, input nibble_t got, input nibble_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("Fail at %0t: %s = %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic bus_write(input reg_addr_t a, input word_t d);
        @(negedge clk_i);
        we_i    = 1'b1;
        addr_i  = a;
        wdata_i = d;
        @(negedge clk_i);
        we_i = 1'b0;
    endtask

    task automatic bus_read(input reg_addr_t a, output word_t d);
        @(negedge clk_i);
        re_i   = 1'b1;
        addr_i = a;
        @(negedge clk_i);
        re_i = 1'b0;
        d    = rdata_o;
    endtask

    task automatic wait_idle(output word_t st);
        bus_read(CTRL_REG, st);
        while (st[STAT_BUSY]) begin
            bus_read(CTRL_REG, st);
        end
    endtask

    task automatic push_field(input word_t v, input int n, input logic lsb);
        for (int i = 0; i < n; i++) begin
            exp_q.push_back(v[4 * nib_pos(i, n, lsb) +: 4]);
        end
    endtask

    task automatic run_transfer(input int t);
        word_t cyc;
        word_t ctrl;
        word_t stray;
        word_t st;
        word_t exp_st;
        word_t rd;
        word_t cmd_w;
        word_t addr_w;
        word_t wdata_w;
        logic  is_rd;
        logic  lsb;
        logic  both;
        int    a_cnt;
        int    d_cnt;
        int    n_cnt;
        int    d_eff;

        is_rd   = take_bits(1) != 0;
        lsb     = take_bits(1) != 0;
        both    = take_bits(1) != 0;
        a_cnt   = int'(take_bits(3)) % 7;
        d_cnt   = int'(take_bits(4));
        n_cnt   = int'(take_bits(3)) + 1;
        cmd_w   = take_bits(8);
        addr_w  = take_bits(32);
        wdata_w = take_bits(32);
        // first transfers cover both orders with no address phase
        if (t < 4) begin
            a_cnt = 0;
            lsb   = t[0];
            is_rd = t[1];
        end
        d_eff = is_rd ? d_cnt : 0;

        cyc                          = '0;
        cyc[ADDR_NIB_LSB +: 4]       = nib_cnt_t'(a_cnt);
        cyc[DUMMY_LSB +: 4]          = dummy_cnt_t'(d_cnt);
        cyc[DATA_NIB_LSB +: 4]       = nib_cnt_t'(n_cnt);
        bus_write(CYCLE_REG, cyc);
        bus_write(ADDR_REG, addr_w);
        bus_write(CMD_REG, cmd_w);
        bus_write(WDATA_REG, wdata_w);
        bus_read(CYCLE_REG, rd);
        check_word("CYCLE_REG", rd, cyc);
        bus_read(ADDR_REG, rd);
        check_word("ADDR_REG", rd, addr_w);
        bus_read(CMD_REG, rd);
        check_word("CMD_REG", rd, cmd_w);
        bus_read(WDATA_REG, rd);
        check_word("WDATA_REG", rd, wdata_w);

        cur_read = is_rd;
        cur_lsb  = lsb;
        cur_a    = a_cnt;
        cur_d    = d_eff;
        cur_n    = n_cnt;
        for (int i = 0; i < FLASH_DEPTH; i++) begin
            flash_mem[i] = nibble_t'(take_bits(4));
        end
        exp_q.delete();
        push_field(cmd_w, 2, lsb);
        push_field(addr_w, a_cnt, lsb);
        if (!is_rd) begin
            push_field(wdata_w, n_cnt, lsb);
        end

        ctrl                = '0;
        ctrl[CTRL_START_RD] = is_rd;
        ctrl[CTRL_START_WR] = !is_rd || both;
        ctrl[CTRL_LSB]      = lsb;
        bus_write(CTRL_REG, ctrl);
        check_count("csb_o", int'(csb_o), 0);
        check_count("intr_rx_o", int'(intr_rx_o), 0);
        check_count("intr_tx_o", int'(intr_tx_o), 0);

        // both starts and the other order while busy
        if (t % 5 == 2) begin
            stray                = '0;
            stray[CTRL_START_RD] = 1'b1;
            stray[CTRL_START_WR] = 1'b1;
            stray[CTRL_LSB]      = !lsb;
            bus_write(CTRL_REG, stray);
        end

        wait_idle(st);
        exp_st               = '0;
        exp_st[STAT_RD_DONE] = is_rd;
        exp_st[STAT_WR_DONE] = !is_rd;
        exp_st[STAT_LSB]     = lsb;
        check_word("CTRL_REG status", st, exp_st);
        check_count("intr_rx_o", int'(intr_rx_o), int'(is_rd));
        check_count("intr_tx_o", int'(intr_tx_o), int'(!is_rd));
        check_count("csb low cycles", csb_cycles, 2 * (2 + a_cnt + d_eff + n_cnt));
        check_count("transfers started", csb_falls, t + 1);
        check_count("captured nibbles", tx_q.size(), exp_q.size());
        foreach (exp_q[i]) begin
            check_nibble("qspi_o", tx_q[i], exp_q[i]);
        end
        if (is_rd) begin
            check_count("read nibbles", rx_q.size(), n_cnt);
            bus_read(RDATA_REG, rd);
            check_word("RDATA_REG", rd, read_model());
        end
    endtask

    // flash side, sampled mid-cycle
    always @(negedge clk_i) begin
        if (!csb_o) begin
            if (csb_prev) begin
                csb_falls  = csb_falls + 1;
                csb_cycles = 0;
                sck_idx    = 0;
                tx_q.delete();
                rx_q.delete();
            end
            csb_cycles = csb_cycles + 1;
            check_nibble("qspi_oe_o", qspi_oe_o, expected_oe(sck_idx));
            if (!sclk_o) begin
                if (cur_read && sck_idx < FLASH_DEPTH) begin
                    qspi_i = flash_mem[sck_idx];
                    if (sck_idx >= 2 + cur_a + cur_d) begin
                        rx_q.push_back(flash_mem[sck_idx]);
                    end
                end
            end else begin
                if (!cur_read || sck_idx < 2 + cur_a) begin
                    tx_q.push_back(qspi_o);
                end
                sck_idx = sck_idx + 1;
            end
        end
        csb_prev = csb_o;
    end

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLES) begin
            abort_run($sformatf("Timeout: test did not finish in %0d cycles", MAX_CYCLES));
        end
    end

    initial begin
        rst_ni   = 1'b0;
        we_i     = 1'b0;
        re_i     = 1'b0;
        addr_i   = '0;
        wdata_i  = '0;
        cur_read = 1'b0;
        cur_lsb  = 1'b0;
        cur_a    = 0;
        cur_d    = 0;
        cur_n    = 1;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_ni = 1'b1;
        for (int t = 0; t < NUM_XFERS; t++) begin
            run_transfer(t);
        end
        repeat (4) @(negedge clk_i);
        check_count("transfers started", csb_falls, NUM_XFERS);
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== project.f ====
verilog/qspi_pkg.sv
verilog/qspi_regs.sv
verilog/qspi_sequencer.sv
verilog/qspi_tx_shift.sv
verilog/qspi_rx_shift.sv
verilog/qspi_core.sv
test/qspi_core_props.sv
test/qspi_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := qspi_core_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
